//--- project.f
src/dino_pkg.sv
src/vga_timing.sv
src/scene_regs.sv
src/sky_clock.sv
src/scenery_painter.sv
src/score_overlay.sv
src/dino_display.sv
+incdir+verif
verif/dino_tb.sv

//--- verif/scene_model.svh
`ifndef SCENE_MODEL_SVH
`define SCENE_MODEL_SVH

// Sync pulses are low across their window, high elsewhere
function automatic logic expected_hs(input int h);
    int start;
    start = int'(dino_pkg::H_ACTIVE) + int'(dino_pkg::H_FRONT);
    return !((h >= start) && (h < start + int'(dino_pkg::H_SYNC)));
endfunction

function automatic logic expected_vs(input int v);
    int start;
    start = int'(dino_pkg::V_ACTIVE) + int'(dino_pkg::V_FRONT);
    return !((v >= start) && (v < start + int'(dino_pkg::V_SYNC)));
endfunction

function automatic logic expected_blank_n(input int h, input int v);
    return (h < int'(dino_pkg::H_ACTIVE)) && (v < int'(dino_pkg::V_ACTIVE));
endfunction

// One drift step, wrapping back to zero after CLOUD_WRAP
function automatic int advance_offset(input int offset);
    if (offset == int'(dino_pkg::CLOUD_WRAP)) begin
        return 0;
    end
    return offset + 1;
endfunction

function automatic logic cloud_covers(input int c, input int h, input int v, input int offset);
    int dx_near;
    int dx_far;
    int dy;
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < dino_pkg::PUFF_COUNT; p++) begin
        dx_near = h - (int'(dino_pkg::CLOUD_PUFF_X[c][p]) + offset);
        dx_far  = dx_near + int'(dino_pkg::CLOUD_WRAP);
        dy      = v - int'(dino_pkg::CLOUD_PUFF_Y[c][p]);
        if ((dx_near * dx_near + dy * dy < dino_pkg::PUFF_R2) ||
            (dx_far * dx_far + dy * dy < dino_pkg::PUFF_R2)) begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

function automatic dino_pkg::rgb_t scene_pixel(input int h, input int v, input logic night,
                                               input int offset);
    dino_pkg::rgb_t color;
    int d2;
    if (v < int'(dino_pkg::HORIZON_ROW)) begin
        color = night ? dino_pkg::NIGHT_SKY : dino_pkg::DAY_SKY;
    end else if (v == int'(dino_pkg::HORIZON_ROW)) begin
        color = dino_pkg::INK;
    end else if (v <= int'(dino_pkg::BAND_ROW)) begin
        color = dino_pkg::GROUND_LIGHT;
    end else begin
        color = dino_pkg::GROUND_DARK;
    end
    d2 = (h - int'(dino_pkg::SUN_X)) ** 2 + (v - int'(dino_pkg::SUN_Y)) ** 2;
    if (d2 < dino_pkg::SUN_CORE_R2) begin
        color = dino_pkg::SUN_CORE;
    end else if ((d2 > dino_pkg::SUN_CORE_R2) && (d2 < dino_pkg::SUN_GLOW_R2)) begin
        color = dino_pkg::SUN_GLOW;
    end
    // Cloud 3 ends up on top
    for (int c = 0; c < dino_pkg::CLOUD_COUNT; c++) begin
        if (cloud_covers(c, h, v, offset)) begin
            color = dino_pkg::CLOUD_COLOR[c];
        end
    end
    return color;
endfunction

function automatic logic score_ink(input int h, input int v, input dino_pkg::scene_regs_t regs);
    int col;
    int row;
    logic [7:0] glyph;
    col = h - int'(regs.score_x);
    row = v - int'(regs.score_y);
    if ((col < 0) || (col > 7) || (row < 0) || (row > 7) || (regs.score > 4'd9)) begin
        return 1'b0;
    end
    glyph = dino_pkg::FONT[regs.score][row];
    return glyph[7 - col];
endfunction

function automatic dino_pkg::rgb_t pixel_expected(input int h, input int v, input logic night,
                                                  input int offset,
                                                  input dino_pkg::scene_regs_t regs);
    if (score_ink(h, v, regs)) begin
        return dino_pkg::INK;
    end
    if (expected_blank_n(h, v)) begin
        return scene_pixel(h, v, night, offset);
    end
    return '0;
endfunction

`endif

//--- verif/dino_tb.sv
module dino_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYCLES   = 1600 * 525;
    localparam int RUN_CYCLES     = FRAME_CYCLES * 5 / 2;
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 1000;
    localparam logic [31:0] SEED  = 32'h26248aca;
    localparam dino_pkg::tick_count_t NIGHT_CYCLES = 32'd900000;
    localparam dino_pkg::tick_count_t CLOUD_CYCLES = 32'd20000;

    logic clk;
    logic reset;
    logic chipselect;
    logic write;
    logic [8:0] address;
    logic [31:0] writedata;
    dino_pkg::color8_t vga_r;
    dino_pkg::color8_t vga_g;
    dino_pkg::color8_t vga_b;
    logic vga_clk;
    logic vga_hs;
    logic vga_vs;
    logic vga_blank_n;
    logic vga_sync_n;

    // Reference state, stepped at each falling edge for the next rising edge
    int m_h;
    int m_v;
    dino_pkg::scene_regs_t m_regs;
    logic m_night;
    int m_night_timer;
    int m_drift_count;
    int m_offset;
    dino_pkg::rgb_t m_pixel;

    logic [31:0] rng;
    int sync_errors = 0;
    int pixel_errors = 0;
    int other_errors = 0;
    int night_pixels = 0;
    int ink_pixels = 0;
    int cloud_pixels = 0;
    int cycle_count = 0;
    logic dut_night_seen = 1'b0;

    `include "scene_model.svh"

    dino_display #(
        .NIGHT_CYCLES (NIGHT_CYCLES),
        .CLOUD_CYCLES (CLOUD_CYCLES)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic model_reset();
        m_h = 0;
        m_v = 0;
        m_regs = '{score: 4'd0, score_x: dino_pkg::SCORE_X_RESET,
                   score_y: dino_pkg::SCORE_Y_RESET};
        m_night = 1'b0;
        m_night_timer = 0;
        m_drift_count = 0;
        m_offset = 0;
        m_pixel = '0;
    endtask

    task automatic report_sync(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            sync_errors++;
            $display("[ERROR] %s expected %0b actual %0b at h=%0d v=%0d", name, exp, act, m_h, m_v);
        end
    endtask

    task automatic model_step();
        m_pixel = pixel_expected(m_h, m_v, m_night, m_offset, m_regs);
        if (score_ink(m_h, m_v, m_regs)) ink_pixels++;
        if (m_pixel == dino_pkg::NIGHT_SKY) night_pixels++;
        for (int c = 0; c < dino_pkg::CLOUD_COUNT; c++) begin
            if (m_pixel == dino_pkg::CLOUD_COLOR[c]) cloud_pixels++;
        end
        if (chipselect && write) begin
            case (address)
                dino_pkg::ADDR_SCORE:   m_regs.score = writedata[3:0];
                dino_pkg::ADDR_SCORE_X: m_regs.score_x = writedata[7:0];
                dino_pkg::ADDR_SCORE_Y: m_regs.score_y = writedata[7:0];
                default: ;
            endcase
        end
        if (m_night_timer == NIGHT_CYCLES) m_night = 1'b1;
        m_night_timer++;
        m_drift_count++;
        if (m_drift_count == CLOUD_CYCLES) begin
            m_drift_count = 0;
            m_offset = advance_offset(m_offset);
        end
        if (m_h == int'(dino_pkg::H_TOTAL) - 1) begin
            m_h = 0;
            m_v = (m_v == int'(dino_pkg::V_TOTAL) - 1) ? 0 : m_v + 1;
        end else begin
            m_h++;
        end
    endtask

    task automatic check_outputs();
        dino_pkg::rgb_t actual;
        actual = {vga_r, vga_g, vga_b};
        report_sync("hsync", expected_hs(m_h), vga_hs);
        report_sync("vsync", expected_vs(m_v), vga_vs);
        report_sync("blank_n", expected_blank_n(m_h, m_v), vga_blank_n);
        report_sync("pixel_clock", (m_h % 2) == 1, vga_clk);
        report_sync("sync_n", 1'b0, vga_sync_n);
        if (actual !== m_pixel) begin
            pixel_errors++;
            $display("[ERROR] pixel_color expected %06h actual %06h at h=%0d v=%0d",
                     m_pixel, actual, m_h, m_v);
        end
        if (actual == dino_pkg::NIGHT_SKY) dut_night_seen = 1'b1;
        if (dut_night_seen && (actual == dino_pkg::DAY_SKY)) begin
            other_errors++;
            $display("Sky went back to the day colour after night at h=%0d v=%0d", m_h, m_v);
        end
    endtask

    // Wrap rule run through the offset step, from reset and from just below the wrap
    task automatic check_offset_wrap();
        int o;
        o = 0;
        repeat (1283) o = advance_offset(o);
        if (o != 1283 % (int'(dino_pkg::CLOUD_WRAP) + 1)) begin
            other_errors++;
            $display("[ERROR] cloud_wrap_from_reset expected %0d actual %0d",
                     1283 % (int'(dino_pkg::CLOUD_WRAP) + 1), o);
        end
        o = int'(dino_pkg::CLOUD_WRAP) - 2;
        repeat (4) o = advance_offset(o);
        // 1278, 1279, 1280, 0, 1
        if (o != 1) begin
            other_errors++;
            $display("[ERROR] cloud_wrap_near_limit expected 1 actual %0d", o);
        end
    endtask

    task automatic drive_bus();
        rng = lcg_next(rng);
        if ((rng[31:16] % 2000) == 0) begin
            rng = lcg_next(rng);
            chipselect <= 1'b1;
            write <= 1'b1;
            address <= {7'd0, rng[17:16]};
            rng = lcg_next(rng);
            writedata <= rng;
        end else begin
            chipselect <= 1'b0;
            write <= 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            model_reset();
        end else begin
            check_outputs();
            model_step();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        chipselect = 1'b0;
        write = 1'b0;
        address = '0;
        writedata = '0;
        rng = SEED;
        check_offset_wrap();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (RUN_CYCLES) begin
            @(posedge clk);
            drive_bus();
        end
        @(posedge clk);
        if (night_pixels == 0) begin
            other_errors++;
            $display("Night sky never appeared during the run");
        end
        if (ink_pixels == 0) begin
            other_errors++;
            $display("No score digit pixel was drawn during the run");
        end
        if (cloud_pixels == 0) begin
            other_errors++;
            $display("No cloud pixel was drawn during the run");
        end
        $display("Errors: sync %0d, pixel %0d, other %0d", sync_errors, pixel_errors,
                 other_errors);
        if (sync_errors + pixel_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/dino_display.sv
module dino_display #(
    parameter dino_pkg::tick_count_t NIGHT_CYCLES = 32'd550000000,
    parameter dino_pkg::tick_count_t CLOUD_CYCLES = 32'd8000000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              chipselect,
    input  logic              write,
    input  logic [8:0]        address,
    input  logic [31:0]       writedata,
    output dino_pkg::color8_t vga_r,
    output dino_pkg::color8_t vga_g,
    output dino_pkg::color8_t vga_b,
    output logic              vga_clk,
    output logic              vga_hs,
    output logic              vga_vs,
    output logic              vga_blank_n,
    output logic              vga_sync_n
);

    dino_pkg::hcount_t       hcount;
    dino_pkg::vcount_t       vcount;
    dino_pkg::scene_regs_t   regs;
    logic                    night;
    dino_pkg::cloud_offset_t cloud_offset;
    dino_pkg::rgb_t          scene_color;
    logic                    ink;
    dino_pkg::rgb_t          pixel_q;

    vga_timing timing (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n),
        .vga_clk     (vga_clk)
    );

    scene_regs regs_block (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .regs       (regs)
    );

    sky_clock #(
        .NIGHT_CYCLES (NIGHT_CYCLES),
        .CLOUD_CYCLES (CLOUD_CYCLES)
    ) clock_block (
        .clk          (clk),
        .reset        (reset),
        .night        (night),
        .cloud_offset (cloud_offset)
    );

    scenery_painter painter (
        .hcount       (hcount),
        .vcount       (vcount),
        .night        (night),
        .cloud_offset (cloud_offset),
        .scene_color  (scene_color)
    );

    score_overlay overlay (
        .hcount (hcount),
        .vcount (vcount),
        .regs   (regs),
        .ink    (ink)
    );

    // One cycle behind the syncs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pixel_q <= '0;
        end else if (ink) begin
            pixel_q <= dino_pkg::INK;
        end else if (vga_blank_n) begin
            pixel_q <= scene_color;
        end else begin
            pixel_q <= '0;
        end
    end

    assign vga_r = pixel_q.r;
    assign vga_g = pixel_q.g;
    assign vga_b = pixel_q.b;

endmodule

//--- src/score_overlay.sv
module score_overlay (
    input  dino_pkg::hcount_t     hcount,
    input  dino_pkg::vcount_t     vcount,
    input  dino_pkg::scene_regs_t regs,
    output logic                  ink
);

    dino_pkg::hcount_t col_off;
    dino_pkg::vcount_t row_off;
    logic              in_box;
    logic              valid_digit;
    logic [2:0]        bit_sel;
    logic [7:0]        glyph_row;

    // Offsets left or above the box wrap to large values and fail the range test
    assign col_off = hcount - dino_pkg::hcount_t'(regs.score_x);
    assign row_off = vcount - dino_pkg::vcount_t'(regs.score_y);
    assign in_box  = (col_off < 11'd8) && (row_off < 10'd8);

    assign valid_digit = (regs.score <= 4'd9);
    assign bit_sel     = 3'd7 - col_off[2:0];

    always_comb begin
        glyph_row = 8'h00;
        if (valid_digit) begin
            glyph_row = dino_pkg::FONT[regs.score][row_off[2:0]];
        end
    end

    assign ink = in_box && glyph_row[bit_sel];

endmodule

//--- src/scenery_painter.sv
module scenery_painter (
    input  dino_pkg::hcount_t       hcount,
    input  dino_pkg::vcount_t       vcount,
    input  logic                    night,
    input  dino_pkg::cloud_offset_t cloud_offset,
    output dino_pkg::rgb_t          scene_color
);

    // Signed pixel position and the two cloud shifts
    int x;
    int y;
    int shift_near;
    int shift_far;
    int sun_d2;

    logic [dino_pkg::CLOUD_COUNT-1:0] cloud_on;
    logic                             in_glow;
    logic                             in_core;
    dino_pkg::rgb_t                   sky_color;
    dino_pkg::rgb_t                   base_color;

    function automatic int dist2(input int dx, input int dy);
        return dx * dx + dy * dy;
    endfunction

    // True if any puff of cloud c covers (px, py) with the given x shift
    function automatic logic puff_hit(
        input int c,
        input int px,
        input int py,
        input int shift
    );
        logic hit;
        int   cx;
        int   cy;
        hit = 1'b0;
        for (int p = 0; p < dino_pkg::PUFF_COUNT; p++) begin
            cx = int'(dino_pkg::CLOUD_PUFF_X[c][p]) + shift;
            cy = int'(dino_pkg::CLOUD_PUFF_Y[c][p]);
            if (dist2(px - cx, py - cy) < dino_pkg::PUFF_R2) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign x          = int'(hcount);
    assign y          = int'(vcount);
    assign shift_near = int'(cloud_offset);
    assign shift_far  = int'(cloud_offset) - int'(dino_pkg::CLOUD_WRAP);

    assign sun_d2  = dist2(x - int'(dino_pkg::SUN_X), y - int'(dino_pkg::SUN_Y));
    assign in_glow = (sun_d2 > dino_pkg::SUN_CORE_R2) && (sun_d2 < dino_pkg::SUN_GLOW_R2);
    assign in_core = (sun_d2 < dino_pkg::SUN_CORE_R2);

    assign sky_color = night ? dino_pkg::NIGHT_SKY : dino_pkg::DAY_SKY;

    // Sky, ground line, then the two ground bands
    always_comb begin
        if (vcount < dino_pkg::HORIZON_ROW) begin
            base_color = sky_color;
        end else if (vcount == dino_pkg::HORIZON_ROW) begin
            base_color = dino_pkg::INK;
        end else if (vcount <= dino_pkg::BAND_ROW) begin
            base_color = dino_pkg::GROUND_LIGHT;
        end else begin
            base_color = dino_pkg::GROUND_DARK;
        end
    end

    // A cloud leaving the right edge reappears from the left
    always_comb begin
        for (int c = 0; c < dino_pkg::CLOUD_COUNT; c++) begin
            cloud_on[c] = puff_hit(c, x, y, shift_near) || puff_hit(c, x, y, shift_far);
        end
    end

    // Later layers win
    always_comb begin
        scene_color = base_color;
        if (in_glow) begin
            scene_color = dino_pkg::SUN_GLOW;
        end
        if (in_core) begin
            scene_color = dino_pkg::SUN_CORE;
        end
        for (int c = 0; c < dino_pkg::CLOUD_COUNT; c++) begin
            if (cloud_on[c]) begin
                scene_color = dino_pkg::CLOUD_COLOR[c];
            end
        end
    end

endmodule

//--- src/sky_clock.sv
module sky_clock #(
    parameter dino_pkg::tick_count_t NIGHT_CYCLES = 32'd550000000,
    parameter dino_pkg::tick_count_t CLOUD_CYCLES = 32'd8000000
) (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    night,
    output dino_pkg::cloud_offset_t cloud_offset
);

    dino_pkg::tick_count_t night_timer;
    dino_pkg::tick_count_t drift_count;
    logic                  drift_tick;

    // Night latches once and never clears
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            night_timer <= '0;
            night       <= 1'b0;
        end else begin
            night_timer <= night_timer + 32'd1;
            if (night_timer == NIGHT_CYCLES) begin
                night <= 1'b1;
            end
        end
    end

    // One drift step per CLOUD_CYCLES clocks
    assign drift_tick = (drift_count == CLOUD_CYCLES - 32'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            drift_count  <= '0;
            cloud_offset <= '0;
        end else begin
            drift_count <= drift_tick ? '0 : drift_count + 32'd1;
            if (drift_tick) begin
                if (cloud_offset == dino_pkg::CLOUD_WRAP) begin
                    cloud_offset <= '0;
                end else begin
                    cloud_offset <= cloud_offset + 11'd1;
                end
            end
        end
    end

endmodule

//--- src/scene_regs.sv
module scene_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  chipselect,
    input  logic                  write,
    input  logic [8:0]            address,
    input  logic [31:0]           writedata,
    output dino_pkg::scene_regs_t regs
);

    logic wr_en;

    assign wr_en = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs.score   <= '0;
            regs.score_x <= dino_pkg::SCORE_X_RESET;
            regs.score_y <= dino_pkg::SCORE_Y_RESET;
        end else if (wr_en) begin
            case (address)
                dino_pkg::ADDR_SCORE: begin
                    regs.score <= writedata[3:0];
                end
                dino_pkg::ADDR_SCORE_X: begin
                    regs.score_x <= writedata[7:0];
                end
                dino_pkg::ADDR_SCORE_Y: begin
                    regs.score_y <= writedata[7:0];
                end
                // Unmapped addresses are dropped
                default: begin
                end
            endcase
        end
    end

endmodule

//--- src/vga_timing.sv
module vga_timing (
    input  logic              clk,
    input  logic              reset,
    output dino_pkg::hcount_t hcount,
    output dino_pkg::vcount_t vcount,
    output logic              vga_hs,
    output logic              vga_vs,
    output logic              vga_blank_n,
    output logic              vga_sync_n,
    output logic              vga_clk
);

    localparam dino_pkg::hcount_t H_LAST   = dino_pkg::H_TOTAL - 11'd1;
    localparam dino_pkg::hcount_t HS_START = dino_pkg::H_ACTIVE + dino_pkg::H_FRONT;
    localparam dino_pkg::hcount_t HS_END   = HS_START + dino_pkg::H_SYNC;

    localparam dino_pkg::vcount_t V_LAST   = dino_pkg::vcount_t'(dino_pkg::V_TOTAL - 11'd1);
    localparam dino_pkg::vcount_t VS_START =
        dino_pkg::vcount_t'(dino_pkg::V_ACTIVE + dino_pkg::V_FRONT);
    localparam dino_pkg::vcount_t VS_END   =
        VS_START + dino_pkg::vcount_t'(dino_pkg::V_SYNC);
    localparam dino_pkg::vcount_t V_VISIBLE = dino_pkg::vcount_t'(dino_pkg::V_ACTIVE);

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (hcount == H_LAST);
    assign end_of_frame = (vcount == V_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            hcount <= end_of_line ? '0 : hcount + 11'd1;
            // Line advances only when the pixel counter wraps
            if (end_of_line) begin
                vcount <= end_of_frame ? '0 : vcount + 10'd1;
            end
        end
    end

    assign vga_hs      = !((hcount >= HS_START) && (hcount < HS_END));
    assign vga_vs      = !((vcount >= VS_START) && (vcount < VS_END));
    assign vga_blank_n = (hcount < dino_pkg::H_ACTIVE) && (vcount < V_VISIBLE);
    assign vga_sync_n  = 1'b0;
    assign vga_clk     = hcount[0];

endmodule

//--- src/dino_pkg.sv
package dino_pkg;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [7:0]  color8_t;
    typedef logic [3:0]  digit_t;
    typedef logic [7:0]  score_pos_t;
    typedef logic [31:0] tick_count_t;
    typedef logic [10:0] cloud_offset_t;

    typedef struct packed {
        color8_t r;
        color8_t g;
        color8_t b;
    } rgb_t;

    typedef struct packed {
        digit_t     score;
        score_pos_t score_x;
        score_pos_t score_y;
    } scene_regs_t;

    // 1280x480 visible inside a 1600x525 frame
    localparam logic [10:0] H_ACTIVE = 11'd1280;
    localparam logic [10:0] H_FRONT  = 11'd32;
    localparam logic [10:0] H_SYNC   = 11'd192;
    localparam logic [10:0] H_BACK   = 11'd96;
    localparam logic [10:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam logic [10:0] V_ACTIVE = 11'd480;
    localparam logic [10:0] V_FRONT  = 11'd10;
    localparam logic [10:0] V_SYNC   = 11'd2;
    localparam logic [10:0] V_BACK   = 11'd33;
    localparam logic [10:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam vcount_t HORIZON_ROW = 10'd280;
    localparam vcount_t BAND_ROW    = 10'd300;

    localparam rgb_t DAY_SKY      = '{r: 8'd135, g: 8'd206, b: 8'd235};
    localparam rgb_t NIGHT_SKY    = '{r: 8'd10,  g: 8'd10,  b: 8'd40};
    localparam rgb_t GROUND_LIGHT = '{r: 8'd139, g: 8'd69,  b: 8'd19};
    localparam rgb_t GROUND_DARK  = '{r: 8'd100, g: 8'd40,  b: 8'd10};
    localparam rgb_t SUN_CORE     = '{r: 8'd255, g: 8'd255, b: 8'd0};
    localparam rgb_t SUN_GLOW     = '{r: 8'd255, g: 8'd255, b: 8'd100};
    localparam rgb_t INK          = '{r: 8'd0,   g: 8'd0,   b: 8'd0};

    localparam hcount_t SUN_X       = 11'd1150;
    localparam vcount_t SUN_Y       = 10'd80;
    localparam int      SUN_CORE_R2 = 900;
    localparam int      SUN_GLOW_R2 = 1200;

    localparam int            CLOUD_COUNT = 3;
    localparam int            PUFF_COUNT  = 6;
    localparam cloud_offset_t CLOUD_WRAP  = 11'd1280;
    localparam int            PUFF_R2     = 100;

    // Puff centres at zero drift, one row per cloud
    localparam hcount_t CLOUD_PUFF_X [CLOUD_COUNT][PUFF_COUNT] = '{
        '{11'd235, 11'd245, 11'd255, 11'd245, 11'd255, 11'd265},
        '{11'd440, 11'd450, 11'd460, 11'd440, 11'd450, 11'd460},
        '{11'd690, 11'd700, 11'd710, 11'd690, 11'd700, 11'd710}
    };
    localparam vcount_t CLOUD_PUFF_Y [CLOUD_COUNT][PUFF_COUNT] = '{
        '{10'd70,  10'd65, 10'd65, 10'd75,  10'd75,  10'd70},
        '{10'd100, 10'd95, 10'd95, 10'd105, 10'd110, 10'd105},
        '{10'd60,  10'd55, 10'd55, 10'd65,  10'd70,  10'd65}
    };
    localparam rgb_t CLOUD_COLOR [CLOUD_COUNT] = '{
        '{r: 8'd255, g: 8'd255, b: 8'd255},
        '{r: 8'd250, g: 8'd250, b: 8'd250},
        '{r: 8'd245, g: 8'd245, b: 8'd245}
    };

    // 8x8 glyphs, MSB is the leftmost pixel
    localparam logic [7:0] FONT [10][8] = '{
        '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
        '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
    };

    localparam logic [8:0] ADDR_SCORE   = 9'd0;
    localparam logic [8:0] ADDR_SCORE_X = 9'd1;
    localparam logic [8:0] ADDR_SCORE_Y = 9'd2;

    localparam score_pos_t SCORE_X_RESET = 8'd25;
    localparam score_pos_t SCORE_Y_RESET = 8'd41;

endpackage
